//--- model_erase_vector.sv
// NTM write head erase vector, e(t;k) = sigmoid(e^(t;k))
// One element per e_in_enable strobe, k from 0 to W-1
// Timing equals the vector logistic block, no added cycles
// Q8.8 data, W up to 255

`timescale 1ns/1ps

module model_erase_vector (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  output logic             ready,
  input  logic             e_in_enable,
  output logic             e_out_enable,
  input  ntm_pkg::control_t size_w_in,
  input  ntm_pkg::data_t    e_in,
  output ntm_pkg::data_t    e_out
);

  import ntm_pkg::*;

  // Erase names onto generic logistic names
  control_t size_in_vector_logistic;
  data_t    data_in_vector_logistic;
  data_t    data_out_vector_logistic;

  assign size_in_vector_logistic = size_w_in;
  assign data_in_vector_logistic = e_in;
  assign e_out                   = data_out_vector_logistic;

  ////////////////////////////////////////////////////////////
  // Vector logistic
  ////////////////////////////////////////////////////////////

  model_vector_logistic_function vector_logistic_function (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .ready          (ready),
    .data_in_enable (e_in_enable),
    .data_out_enable(e_out_enable),
    .size_in        (size_in_vector_logistic),
    .data_in        (data_in_vector_logistic),
    .data_out       (data_out_vector_logistic)
  );

endmodule

//--- model_scalar_logistic_function.sv
// Two-stage PLAN sigmoid for one Q8.8 sample
// Latency is 2 cycles from in_enable to out_enable, one sample per cycle
// Magnitude saturates at 32767, so -32768 maps like -32767
// Right shifts truncate toward zero on the magnitude
// Result always lies in 0..1.0 (0..256 in Q8.8)

`timescale 1ns/1ps

`include "ntm_params.svh"

module model_scalar_logistic_function (
  input  logic          clk,
  input  logic          reset,
  input  logic          in_enable,
  input  ntm_pkg::data_t data_in,
  output logic          out_enable,
  output ntm_pkg::data_t data_out
);

  import ntm_pkg::*;

  ////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////

  // Largest positive code clips |x|
  localparam data_t MAG_MAX = data_t'({1'b0, {(`NTM_DATA_SIZE-1){1'b1}}});
  // Most negative code has no positive twin
  localparam data_t MAG_MIN = ~MAG_MAX;

  // Segment index
  localparam logic [1:0] SEG_LOW  = 2'd0;
  localparam logic [1:0] SEG_MID  = 2'd1;
  localparam logic [1:0] SEG_HIGH = 2'd2;
  localparam logic [1:0] SEG_SAT  = 2'd3;

  ////////////////////////////////////////////////////////////
  // Stage 1: magnitude, sign, segment
  ////////////////////////////////////////////////////////////

  data_t      abs_in;
  logic [1:0] seg_in;

  logic       s1_valid;
  logic       s1_neg;
  logic [1:0] s1_seg;
  data_t      s1_mag;

  always_comb begin
    // Saturating absolute value
    if (data_in == MAG_MIN) begin
      abs_in = MAG_MAX;
    end else if (data_in[`NTM_DATA_SIZE-1]) begin
      abs_in = -data_in;
    end else begin
      abs_in = data_in;
    end

    // Knee compare, highest first
    if (abs_in >= PLAN_KNEE_3) begin
      seg_in = SEG_SAT;
    end else if (abs_in >= PLAN_KNEE_2) begin
      seg_in = SEG_HIGH;
    end else if (abs_in >= PLAN_KNEE_1) begin
      seg_in = SEG_MID;
    end else begin
      seg_in = SEG_LOW;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_enable;
    end
  end

  // Payload loads with each strobe
  always_ff @(posedge clk) begin
    if (in_enable) begin
      s1_mag <= abs_in;
      s1_neg <= data_in[`NTM_DATA_SIZE-1];
      s1_seg <= seg_in;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2: shift-add and sign fold
  ////////////////////////////////////////////////////////////

  data_t plan_y;
  data_t folded_y;

  always_comb begin
    case (s1_seg)
      // Flat top at 1.0
      SEG_SAT:  plan_y = ONE_DATA;
      // Slope 1/32
      SEG_HIGH: plan_y = (s1_mag >> 5) + PLAN_OFFSET_HIGH;
      // Slope 1/8
      SEG_MID:  plan_y = (s1_mag >> 3) + PLAN_OFFSET_MID;
      // Slope 1/4 around 0.5
      default:  plan_y = (s1_mag >> 2) + HALF_DATA;
    endcase

    // sigmoid(-x) = 1 - sigmoid(x)
    folded_y = s1_neg ? (ONE_DATA - plan_y) : plan_y;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_enable <= 1'b0;
      data_out   <= '0;
    end else begin
      out_enable <= s1_valid;
      if (s1_valid) begin
        data_out <= folded_y;
      end
    end
  end

  // Output code stays inside the unit interval
  assert property (@(posedge clk) disable iff (reset)
    out_enable |-> (data_out >= data_t'(0)) && (data_out <= ONE_DATA))
    else $error("sigmoid output out of range: %0d", data_out);

endmodule

//--- model_vector_logistic_function.sv
// Applies the PLAN sigmoid to W elements, one per input strobe
// start is legal only while ready is high and latches size_in as W
// Strobes while idle or beyond W are dropped
// Each accepted strobe gives one output pulse 2 cycles later, in order
// Without back-pressure the consumer must take every output pulse
// ready returns one cycle after the W-th output, or after start if W is 0

`timescale 1ns/1ps

module model_vector_logistic_function (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  output logic             ready,
  input  logic             data_in_enable,
  output logic             data_out_enable,
  input  ntm_pkg::control_t size_in,
  input  ntm_pkg::data_t    data_in,
  output ntm_pkg::data_t    data_out
);

  import ntm_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Vector in progress
  logic     busy;
  // Latched W
  control_t size_reg;
  // Strobes taken so far
  control_t in_count;
  // Results delivered so far
  control_t out_count;
  control_t out_count_next;

  // Strobe passed on to the pipeline
  logic     accept;
  logic     start_ok;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  assign ready          = ~busy;
  assign start_ok       = start && !busy;
  assign accept         = busy && data_in_enable && (in_count != size_reg);
  assign out_count_next = out_count + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      size_reg  <= '0;
      in_count  <= '0;
      out_count <= '0;
    end else if (start_ok) begin
      // Empty vector never leaves idle
      busy      <= (size_in != '0);
      size_reg  <= size_in;
      in_count  <= '0;
      out_count <= '0;
    end else begin
      if (accept) begin
        in_count <= in_count + 1'b1;
      end
      if (data_out_enable) begin
        out_count <= out_count_next;
        // Back to idle once the last result drains
        if (out_count_next == size_reg) begin
          busy <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  // Two-cycle sigmoid pipeline
  model_scalar_logistic_function scalar_logistic_function (
    .clk       (clk),
    .reset     (reset),
    .in_enable (accept),
    .data_in   (data_in),
    .out_enable(data_out_enable),
    .data_out  (data_out)
  );

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Host must wait for ready
  assert property (@(posedge clk) disable iff (reset)
    start |-> ready)
    else $error("start while busy");

  // Pipeline drains before idle
  assert property (@(posedge clk) disable iff (reset)
    data_out_enable |-> busy)
    else $error("output pulse while idle");

  // Never more results than W
  assert property (@(posedge clk) disable iff (reset)
    busy |-> (out_count <= size_reg))
    else $error("output count beyond size %0d", size_reg);

endmodule

//--- ntm_params.svh
// Sizing for the NTM erase vector datapath
// Data are signed fixed point Q8.8
// Element count is 8 bits, so W is limited to 255
// Changing the fraction bits needs new PLAN constants in ntm_pkg
// Include once per compilation unit; the guard makes repeats harmless

`ifndef NTM_PARAMS_SVH
`define NTM_PARAMS_SVH

////////////////////////////////////////////////////////////
// Data format
////////////////////////////////////////////////////////////

// Total data width, sign included
`define NTM_DATA_SIZE 16

// Bits right of the binary point
`define NTM_FRAC_BITS 8

// Width of the element counter and of the size port
`define NTM_CONTROL_SIZE 8

`endif

//--- ntm_pkg.sv
// Shared types and constants for the erase vector datapath
// Q8.8 codes below assume NTM_FRAC_BITS is 8
// PLAN breakpoints and offsets follow the classic PLAN sigmoid

`include "ntm_params.svh"

package ntm_pkg;

  //////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////

  // Signed Q8.8 sample
  typedef logic signed [`NTM_DATA_SIZE-1:0] data_t;

  // Unsigned element count
  typedef logic [`NTM_CONTROL_SIZE-1:0] control_t;

  //////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////

  // 1.0 and 0.5 in Q8.8
  localparam data_t ONE_DATA  = data_t'(1 << `NTM_FRAC_BITS);
  localparam data_t HALF_DATA = data_t'(1 << (`NTM_FRAC_BITS - 1));

  // Segment offsets, 0.625 and 0.84375
  localparam data_t PLAN_OFFSET_MID  = data_t'(160);
  localparam data_t PLAN_OFFSET_HIGH = data_t'(216);

  // Segment knees on |x|, 1.0, 2.375 and 5.0
  localparam data_t PLAN_KNEE_1 = data_t'(256);
  localparam data_t PLAN_KNEE_2 = data_t'(608);
  localparam data_t PLAN_KNEE_3 = data_t'(1280);

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the erase vector testbench with Verilator.
# Exit status is 0 only when the testbench reports success.

set -u

# Work from the project root
cd "$(dirname "$0")" || exit 1

TOP=tb_model_erase_vector
BUILD_DIR=obj_dir
EXE="V${TOP}"

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

# Compile
verilator --binary --timing --assert \
  -f src.f \
  --top-module "${TOP}" \
  -Mdir "${BUILD_DIR}" \
  -o "${EXE}"
status=$?
if [ ${status} -ne 0 ]; then
  echo "verilator compile failed with status ${status}"
  exit 1
fi

if [ ! -x "${BUILD_DIR}/${EXE}" ]; then
  echo "simulation executable missing"
  exit 1
fi

# Run and keep the output for the search
output=$("./${BUILD_DIR}/${EXE}" 2>&1)
status=$?
printf '%s\n' "${output}"
if [ ${status} -ne 0 ]; then
  echo "simulation exited with status ${status}"
  exit 1
fi

# Decide by the pass message
if printf '%s\n' "${output}" | grep -qx "all tests passed"; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi

//--- src.f
+incdir+.
ntm_pkg.sv
model_scalar_logistic_function.sv
model_vector_logistic_function.sv
model_erase_vector.sv
tb_clock_gen.sv
tb_model_erase_vector.sv

//--- tb_clock_gen.sv
// Clock and reset source for the erase vector testbench
// Reset is held high for RESET_CYCLES rising edges, then released on a falling edge

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic reset
);

  // Free running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release away from the sampling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- tb_model_erase_vector.sv
// Testbench for the erase vector top level
// Inputs change on the falling edge, outputs are sampled on the falling edge
// Expected values come from a PLAN sigmoid model written from the rule table
// Every accepted strobe must give its output exactly 2 cycles later
// Run ends at TIMEOUT_CYCLES if a wait never completes

`timescale 1ns/1ps

module tb_model_erase_vector;

  import ntm_pkg::*;

  // Limit far above the roughly 600 cycles the tests take
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int LATENCY        = 2;

  logic     clk;
  logic     reset;
  logic     start;
  logic     ready;
  logic     e_in_enable;
  logic     e_out_enable;
  control_t size_w_in;
  data_t    e_in;
  data_t    e_out;

  ////////////////////////////////////////////////////////////
  // Bookkeeping
  ////////////////////////////////////////////////////////////

  int          cycle = 0;
  logic [31:0] rng_state = 32'hc0b;
  string       cur_test = "reset";
  // Expected value and output cycle per accepted strobe
  data_t       exp_q[$];
  int          cyc_q[$];
  // Owned by the output monitor
  int          out_total = 0;
  int          monitor_errors = 0;
  int          ready_rise_cycle = -1;
  int          last_pulse_cycle = -1;
  logic        ready_prev = 1'b1;
  // Owned by the stimulus
  int          check_errors;
  int          base_out;
  int          base_errors;
  int          tests_passed = 0;
  int          tests_failed = 0;

  // Breakpoints around every knee, plus both extremes
  localparam data_t DIRECTED [15] = '{
    16'sd0, 16'sd255, -16'sd255, 16'sd256, -16'sd256, 16'sd607, -16'sd607,
    16'sd608, -16'sd608, 16'sd1279, -16'sd1279, 16'sd1280, -16'sd1280,
    16'sh7fff, 16'sh8000
  };

  tb_clock_gen clock_gen_i (
    .clk  (clk),
    .reset(reset)
  );

  model_erase_vector dut_i (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .ready       (ready),
    .e_in_enable (e_in_enable),
    .e_out_enable(e_out_enable),
    .size_w_in   (size_w_in),
    .e_in        (e_in),
    .e_out       (e_out)
  );

  ////////////////////////////////////////////////////////////
  // Reference model and random source
  ////////////////////////////////////////////////////////////

  // PLAN sigmoid on integer codes
  function automatic data_t plan_sigmoid(input data_t x);
    int a;
    int y;
    a = int'(x);
    if (a < 0)
      a = -a;
    // -32768 has no positive twin
    if (a > 32767)
      a = 32767;
    if (a >= 1280)
      y = 256;
    else if (a >= 608)
      y = a / 32 + 216;
    else if (a >= 256)
      y = a / 8 + 160;
    else
      y = a / 4 + 128;
    if (x < 0)
      y = 256 - y;
    return data_t'(y);
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] r;
    r = s;
    r = r ^ (r << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  // Half small values across all knees, half full range
  task automatic random_sample(output data_t v);
    rng_state = xorshift32(rng_state);
    if (rng_state[20])
      v = data_t'({{4{rng_state[11]}}, rng_state[11:0]});
    else
      v = data_t'(rng_state[15:0]);
  endtask

  task automatic random_gap(output int g);
    rng_state = xorshift32(rng_state);
    g = int'(rng_state[1:0]);
  endtask

  ////////////////////////////////////////////////////////////
  // Cycle counter and timeout
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output monitor and compare
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin : compare_outputs
    data_t exp_val;
    int    exp_cyc;
    if (!reset) begin
      if (ready && !ready_prev)
        ready_rise_cycle = cycle;
      ready_prev = ready;
      if (e_out_enable) begin
        out_total++;
        last_pulse_cycle = cycle;
        if (exp_q.size() == 0) begin
          $display("%s: output pulse with no pending input, e_out %0d", cur_test, e_out);
          monitor_errors++;
        end else begin
          exp_val = exp_q.pop_front();
          exp_cyc = cyc_q.pop_front();
          if (e_out !== exp_val) begin
            $display("CHECK FAILED %s e_out: expected %0d actual %0d",
                     cur_test, exp_val, e_out);
            monitor_errors++;
          end
          if (cycle != exp_cyc) begin
            $display("CHECK FAILED %s latency: expected cycle %0d actual cycle %0d",
                     cur_test, exp_cyc, cycle);
            monitor_errors++;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus tasks, all entered on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic begin_test(input string name);
    cur_test     = name;
    check_errors = 0;
    base_out     = out_total;
    base_errors  = monitor_errors;
  endtask

  task automatic end_test();
    int errors;
    errors = check_errors + (monitor_errors - base_errors);
    if (errors == 0) begin
      $display("test %s: ok", cur_test);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", cur_test, errors);
      tests_failed++;
    end
  endtask

  // Ready must drop one cycle after start, unless W is 0
  task automatic start_vector(input int w);
    logic exp_ready;
    start     = 1'b1;
    size_w_in = control_t'(w);
    @(negedge clk);
    start     = 1'b0;
    exp_ready = (w == 0);
    if (ready !== exp_ready) begin
      $display("CHECK FAILED %s ready after start: expected %0d actual %0d",
               cur_test, exp_ready, ready);
      check_errors++;
    end
  endtask

  task automatic send_element(input data_t value, input bit accepted);
    e_in_enable = 1'b1;
    e_in        = value;
    if (accepted) begin
      exp_q.push_back(plan_sigmoid(value));
      cyc_q.push_back(cycle + LATENCY);
    end
    @(negedge clk);
  endtask

  task automatic idle_cycles(input int n);
    e_in_enable = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // Wait for ready, drain, then check count and ready timing
  task automatic finish_vector(input int w);
    e_in_enable = 1'b0;
    while (ready !== 1'b1)
      @(negedge clk);
    repeat (4) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%s: %0d expected outputs never arrived", cur_test, exp_q.size());
      check_errors++;
      exp_q.delete();
      cyc_q.delete();
    end
    if (out_total - base_out != w) begin
      $display("CHECK FAILED %s output count: expected %0d actual %0d",
               cur_test, w, out_total - base_out);
      check_errors++;
    end
    if (w > 0 && ready_rise_cycle != last_pulse_cycle + 1) begin
      $display("CHECK FAILED %s ready rise cycle: expected %0d actual %0d",
               cur_test, last_pulse_cycle + 1, ready_rise_cycle);
      check_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    data_t v;
    int    g;
    start       = 1'b0;
    e_in_enable = 1'b0;
    size_w_in   = '0;
    e_in        = '0;
    @(negedge clk);
    while (reset)
      @(negedge clk);

    // Idle outputs straight after reset
    begin_test("reset_state");
    if (ready !== 1'b1) begin
      $display("CHECK FAILED %s ready: expected %0d actual %0d", cur_test, 1, ready);
      check_errors++;
    end
    if (e_out_enable !== 1'b0) begin
      $display("CHECK FAILED %s e_out_enable: expected %0d actual %0d",
               cur_test, 0, e_out_enable);
      check_errors++;
    end
    if (e_out !== data_t'(0)) begin
      $display("CHECK FAILED %s e_out: expected %0d actual %0d", cur_test, 0, e_out);
      check_errors++;
    end
    end_test();

    // Every segment, the sign fold and saturation
    begin_test("directed_breakpoints");
    start_vector(15);
    foreach (DIRECTED[i]) begin
      send_element(DIRECTED[i], 1'b1);
      idle_cycles(1);
    end
    finish_vector(15);
    end_test();

    // Random values with random idle gaps
    begin_test("random_gaps");
    start_vector(64);
    for (int i = 0; i < 64; i++) begin
      random_sample(v);
      send_element(v, 1'b1);
      random_gap(g);
      idle_cycles(g);
    end
    finish_vector(64);
    end_test();

    // One strobe every cycle
    begin_test("full_rate");
    start_vector(200);
    for (int i = 0; i < 200; i++) begin
      random_sample(v);
      send_element(v, 1'b1);
    end
    finish_vector(200);
    end_test();

    // Strobes beyond W, then strobes while idle
    begin_test("ready_sequencing");
    start_vector(5);
    for (int i = 0; i < 8; i++) begin
      random_sample(v);
      send_element(v, i < 5);
    end
    finish_vector(5);
    for (int i = 0; i < 3; i++) begin
      random_sample(v);
      send_element(v, 1'b0);
    end
    idle_cycles(4);
    if (out_total - base_out != 5) begin
      $display("CHECK FAILED %s idle strobes: expected %0d actual %0d",
               cur_test, 5, out_total - base_out);
      check_errors++;
    end
    end_test();

    // Empty vector, then a short one to show state is clear
    begin_test("zero_length");
    start_vector(0);
    idle_cycles(5);
    finish_vector(0);
    start_vector(3);
    for (int i = 0; i < 3; i++) begin
      random_sample(v);
      send_element(v, 1'b1);
    end
    finish_vector(3);
    end_test();

    $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule
